//--- verilog/serial_link_pkg.sv
package serial_link_pkg;

  // Shared by transmitter and receiver
  typedef enum logic [1:0] {
    LINK_IDLE,
    LINK_DATA,
    LINK_CHECK
  } link_state_e;

  // Register map of the configuration port
  typedef enum logic [1:0] {
    CFG_CTRL      = 2'd0,
    CFG_TX_COUNT  = 2'd1,
    CFG_RX_COUNT  = 2'd2,
    CFG_ERR_COUNT = 2'd3
  } cfg_addr_e;

  // Width of each traffic counter
  localparam int unsigned CountWidth = 16;

endpackage

//--- verilog/serial_link_cfg.sv
module serial_link_cfg (
  input  logic                                 rst_ni,
  input  logic                                 rst_n_i,
  input  logic                                 cfg_we_i,
  input  logic                                 cfg_re_i,
  input  serial_link_pkg::cfg_addr_e           cfg_addr_i,
  input  logic [serial_link_pkg::CountWidth-1:0] cfg_wdata_i,
  output logic [serial_link_pkg::CountWidth-1:0] cfg_rdata_o,
  input  logic                                 tx_done_i,
  input  logic                                 rx_done_i,
  input  logic                                 rx_err_i,
  output logic                                 link_en_o
);

  logic [serial_link_pkg::CountWidth-1:0] tx_count_q;
  logic [serial_link_pkg::CountWidth-1:0] rx_count_q;
  logic [serial_link_pkg::CountWidth-1:0] err_count_q;
  logic                                   ctrl_wr;
  logic                                   count_clr;

  assign ctrl_wr   = cfg_we_i && (cfg_addr_i == serial_link_pkg::CFG_CTRL);
  // Bit 1 of a control write is a self-clearing command
  assign count_clr = ctrl_wr && cfg_wdata_i[1];

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      link_en_o <= 1'b0;
    end else if (ctrl_wr) begin
      link_en_o <= cfg_wdata_i[0];
    end
  end

  // Counters wrap at their width
  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      tx_count_q  <= '0;
      rx_count_q  <= '0;
      err_count_q <= '0;
    end else if (count_clr) begin
      tx_count_q  <= '0;
      rx_count_q  <= '0;
      err_count_q <= '0;
    end else begin
      if (tx_done_i) begin
        tx_count_q <= tx_count_q + 1'b1;
      end
      if (rx_done_i) begin
        rx_count_q <= rx_count_q + 1'b1;
      end
      if (rx_err_i) begin
        err_count_q <= err_count_q + 1'b1;
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      cfg_rdata_o <= '0;
    end else if (cfg_re_i) begin
      case (cfg_addr_i)
        serial_link_pkg::CFG_CTRL: begin
          cfg_rdata_o <= {{(serial_link_pkg::CountWidth - 1){1'b0}}, link_en_o};
        end
        serial_link_pkg::CFG_TX_COUNT: begin
          cfg_rdata_o <= tx_count_q;
        end
        serial_link_pkg::CFG_RX_COUNT: begin
          cfg_rdata_o <= rx_count_q;
        end
        serial_link_pkg::CFG_ERR_COUNT: begin
          cfg_rdata_o <= err_count_q;
        end
        default: begin
          cfg_rdata_o <= '0;
        end
      endcase
    end
  end

endmodule

//--- verilog/serial_link_tx.sv
module serial_link_tx #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned LaneWidth = 4
) (
  input  logic                 rst_ni,
  input  logic                 rst_n_i,
  input  logic                 link_en_i,
  input  logic                 tx_valid_i,
  input  logic [DataWidth-1:0] tx_data_i,
  output logic                 tx_ready_o,
  output logic                 lane_valid_o,
  output logic [LaneWidth-1:0] lane_data_o,
  output logic                 tx_done_o
);

  localparam int unsigned BeatCount = DataWidth / LaneWidth;
  localparam int unsigned CntWidth  = $clog2(BeatCount + 1);

  serial_link_pkg::link_state_e state_q;
  logic [CntWidth-1:0]          beat_cnt_q;
  logic [DataWidth-1:0]         shift_q;
  logic [LaneWidth-1:0]         check_q;
  logic                         accept;
  logic                         last_beat;

  // New word only when idle and enabled
  assign tx_ready_o = link_en_i && (state_q == serial_link_pkg::LINK_IDLE);
  assign accept     = tx_valid_i && tx_ready_o;
  assign last_beat  = (beat_cnt_q == CntWidth'(BeatCount));
  assign tx_done_o  = (state_q == serial_link_pkg::LINK_CHECK);

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      state_q      <= serial_link_pkg::LINK_IDLE;
      beat_cnt_q   <= '0;
      lane_valid_o <= 1'b0;
    end else begin
      case (state_q)
        serial_link_pkg::LINK_IDLE: begin
          if (accept) begin
            state_q      <= serial_link_pkg::LINK_DATA;
            beat_cnt_q   <= CntWidth'(1);
            lane_valid_o <= 1'b1;
          end
        end
        serial_link_pkg::LINK_DATA: begin
          if (last_beat) begin
            state_q <= serial_link_pkg::LINK_CHECK;
          end else begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
          end
        end
        serial_link_pkg::LINK_CHECK: begin
          state_q      <= serial_link_pkg::LINK_IDLE;
          lane_valid_o <= 1'b0;
        end
        default: begin
          state_q      <= serial_link_pkg::LINK_IDLE;
          lane_valid_o <= 1'b0;
        end
      endcase
    end
  end

  // Lowest slice goes out at acceptance, the rest from the shifter
  always_ff @(posedge rst_ni) begin
    case (state_q)
      serial_link_pkg::LINK_IDLE: begin
        if (accept) begin
          lane_data_o <= tx_data_i[LaneWidth-1:0];
          shift_q     <= tx_data_i >> LaneWidth;
          check_q     <= tx_data_i[LaneWidth-1:0];
        end
      end
      serial_link_pkg::LINK_DATA: begin
        if (last_beat) begin
          lane_data_o <= check_q;
        end else begin
          lane_data_o <= shift_q[LaneWidth-1:0];
          shift_q     <= shift_q >> LaneWidth;
          check_q     <= check_q ^ shift_q[LaneWidth-1:0];
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/serial_link_rx.sv
module serial_link_rx #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned LaneWidth = 4
) (
  input  logic                 rst_ni,
  input  logic                 rst_n_i,
  input  logic                 link_en_i,
  input  logic                 lane_valid_i,
  input  logic [LaneWidth-1:0] lane_data_i,
  output logic                 rx_valid_o,
  output logic [DataWidth-1:0] rx_data_o,
  output logic                 rx_err_o
);

  localparam int unsigned BeatCount = DataWidth / LaneWidth;
  localparam int unsigned CntWidth  = $clog2(BeatCount + 1);

  serial_link_pkg::link_state_e state_q;
  logic [CntWidth-1:0]          beat_cnt_q;
  logic [DataWidth-1:0]         word_q;
  logic [LaneWidth-1:0]         check_q;
  logic                         beat_valid;
  logic                         last_data;
  logic                         check_ok;

  // Lane is ignored while disabled
  assign beat_valid = lane_valid_i && link_en_i;
  assign last_data  = (beat_cnt_q == CntWidth'(BeatCount - 1));
  assign check_ok   = (lane_data_i == check_q);

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      state_q    <= serial_link_pkg::LINK_IDLE;
      beat_cnt_q <= '0;
      rx_valid_o <= 1'b0;
      rx_err_o   <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      rx_err_o   <= 1'b0;
      if (!link_en_i) begin
        // Partial word is dropped
        state_q    <= serial_link_pkg::LINK_IDLE;
        beat_cnt_q <= '0;
      end else if (beat_valid) begin
        case (state_q)
          serial_link_pkg::LINK_IDLE,
          serial_link_pkg::LINK_DATA: begin
            if (last_data) begin
              state_q    <= serial_link_pkg::LINK_CHECK;
              beat_cnt_q <= '0;
            end else begin
              state_q    <= serial_link_pkg::LINK_DATA;
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
          serial_link_pkg::LINK_CHECK: begin
            rx_valid_o <= check_ok;
            rx_err_o   <= !check_ok;
            state_q    <= serial_link_pkg::LINK_IDLE;
          end
          default: begin
            state_q <= serial_link_pkg::LINK_IDLE;
          end
        endcase
      end
    end
  end

  // First beat lands in the low slice after all shifts
  always_ff @(posedge rst_ni) begin
    if (beat_valid) begin
      if (state_q == serial_link_pkg::LINK_CHECK) begin
        if (check_ok) begin
          rx_data_o <= word_q;
        end
      end else begin
        word_q  <= (word_q >> LaneWidth) | (DataWidth'(lane_data_i) << (DataWidth - LaneWidth));
        check_q <= (state_q == serial_link_pkg::LINK_IDLE) ? lane_data_i
                                                            : check_q ^ lane_data_i;
      end
    end
  end

endmodule

//--- verilog/serial_link.sv
module serial_link #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned LaneWidth = 4
) (
  input  logic                                   rst_ni,
  input  logic                                   rst_n_i,
  input  logic                                   tx_valid_i,
  input  logic [DataWidth-1:0]                   tx_data_i,
  output logic                                   tx_ready_o,
  output logic                                   lane_valid_o,
  output logic [LaneWidth-1:0]                   lane_data_o,
  input  logic                                   lane_valid_i,
  input  logic [LaneWidth-1:0]                   lane_data_i,
  output logic                                   rx_valid_o,
  output logic [DataWidth-1:0]                   rx_data_o,
  output logic                                   rx_err_o,
  input  logic                                   cfg_we_i,
  input  logic                                   cfg_re_i,
  input  serial_link_pkg::cfg_addr_e             cfg_addr_i,
  input  logic [serial_link_pkg::CountWidth-1:0] cfg_wdata_i,
  output logic [serial_link_pkg::CountWidth-1:0] cfg_rdata_o
);

  logic link_en;
  logic tx_done;

  serial_link_cfg u_cfg (
    .rst_ni      ( rst_ni      ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_re_i    ( cfg_re_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .tx_done_i   ( tx_done     ),
    .rx_done_i   ( rx_valid_o  ),
    .rx_err_i    ( rx_err_o    ),
    .link_en_o   ( link_en     )
  );

  serial_link_tx #(
    .DataWidth ( DataWidth ),
    .LaneWidth ( LaneWidth )
  ) u_tx (
    .rst_ni       ( rst_ni       ),
    .rst_n_i      ( rst_n_i      ),
    .link_en_i    ( link_en      ),
    .tx_valid_i   ( tx_valid_i   ),
    .tx_data_i    ( tx_data_i    ),
    .tx_ready_o   ( tx_ready_o   ),
    .lane_valid_o ( lane_valid_o ),
    .lane_data_o  ( lane_data_o  ),
    .tx_done_o    ( tx_done      )
  );

  serial_link_rx #(
    .DataWidth ( DataWidth ),
    .LaneWidth ( LaneWidth )
  ) u_rx (
    .rst_ni       ( rst_ni       ),
    .rst_n_i      ( rst_n_i      ),
    .link_en_i    ( link_en      ),
    .lane_valid_i ( lane_valid_i ),
    .lane_data_i  ( lane_data_i  ),
    .rx_valid_o   ( rx_valid_o   ),
    .rx_data_o    ( rx_data_o    ),
    .rx_err_o     ( rx_err_o     )
  );

endmodule

//--- tb/serial_link_properties.sv
module serial_link_properties #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned LaneWidth = 4
) (
  input logic                 rst_ni,
  input logic                 rst_n_i,
  input logic                 tx_valid_i,
  input logic [DataWidth-1:0] tx_data_i,
  input logic                 tx_ready_i,
  input logic                 lane_valid_i,
  input logic                 rx_valid_i,
  input logic                 rx_err_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Beats = DataWidth / LaneWidth;

  // Length of the current strobe run
  int unsigned run_len_q;

  always_ff @(posedge rst_ni) begin
    if (!rst_n_i) begin
      run_len_q <= 0;
    end else if (lane_valid_i) begin
      run_len_q <= run_len_q + 1;
    end else begin
      run_len_q <= 0;
    end
  end

  tx_hold_a: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> !tx_valid_i || $stable(tx_data_i))
    else $error("tx_data_i changed while the word waited for tx_ready_o");

  rx_pulse_excl_a: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    !(rx_valid_i && rx_err_i))
    else $error("rx_valid_o and rx_err_o high in the same cycle");

  // Strobe starts right after acceptance
  lane_start_a: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    tx_valid_i && tx_ready_i |=> lane_valid_i && (run_len_q == 0))
    else $error("lane_valid_o did not start after acceptance");

  lane_max_a: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    lane_valid_i |-> run_len_q <= Beats)
    else $error("lane_valid_o stayed high too long");

  lane_len_a: assert property (@(posedge rst_ni) disable iff (!rst_n_i)
    $fell(lane_valid_i) |-> run_len_q == Beats + 1)
    else $error("lane_valid_o run had the wrong length");

endmodule

//--- tb/serial_link_tb.sv
module serial_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned DataWidth  = 32;
  localparam int unsigned LaneWidth  = 4;
  localparam int unsigned Beats      = DataWidth / LaneWidth;
  localparam int unsigned Latency    = Beats + 2;
  localparam int unsigned HoldCycles = 8;
  localparam int unsigned CW         = serial_link_pkg::CountWidth;

  typedef enum logic [2:0] {
    OP_SEND,
    OP_WRITE,
    OP_READ,
    OP_HOLD,
    OP_DRAIN
  } op_e;

  typedef struct {
    op_e                        op;
    serial_link_pkg::cfg_addr_e addr;
    logic [DataWidth-1:0]       data;
    logic                       corrupt;
    logic [DataWidth-1:0]       expected;
  } step_t;

  typedef struct {
    logic [DataWidth-1:0] data;
    logic                 corrupt;
    int                   accept_cycle;
  } sb_entry_t;

  logic                       rst_ni;
  logic                       rst_n_i;
  logic                       tx_valid_i;
  logic [DataWidth-1:0]       tx_data_i;
  logic                       tx_ready_o;
  logic                       lane_valid_o;
  logic [LaneWidth-1:0]       lane_data_o;
  logic                       lane_valid_i;
  logic [LaneWidth-1:0]       lane_data_i;
  logic                       rx_valid_o;
  logic [DataWidth-1:0]       rx_data_o;
  logic                       rx_err_o;
  logic                       cfg_we_i;
  logic                       cfg_re_i;
  serial_link_pkg::cfg_addr_e cfg_addr_i;
  logic [CW-1:0]              cfg_wdata_i;
  logic [CW-1:0]              cfg_rdata_o;

  step_t     steps[$];
  sb_entry_t sb[$];
  int        seed = 32'h3699;
  int        cycle_cnt = 0;
  int        checks = 0;
  int        errors = 0;
  logic      flip_armed = 1'b0;
  logic      lane_valid_prev = 1'b0;
  // Reference counts while the table is built
  int        exp_tx;
  int        exp_rx;
  int        exp_err;
  logic      exp_en;

  serial_link #(
    .DataWidth ( DataWidth ),
    .LaneWidth ( LaneWidth )
  ) u_dut (
    .rst_ni       ( rst_ni       ),
    .rst_n_i      ( rst_n_i      ),
    .tx_valid_i   ( tx_valid_i   ),
    .tx_data_i    ( tx_data_i    ),
    .tx_ready_o   ( tx_ready_o   ),
    .lane_valid_o ( lane_valid_o ),
    .lane_data_o  ( lane_data_o  ),
    .lane_valid_i ( lane_valid_i ),
    .lane_data_i  ( lane_data_i  ),
    .rx_valid_o   ( rx_valid_o   ),
    .rx_data_o    ( rx_data_o    ),
    .rx_err_o     ( rx_err_o     ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_re_i     ( cfg_re_i     ),
    .cfg_addr_i   ( cfg_addr_i   ),
    .cfg_wdata_i  ( cfg_wdata_i  ),
    .cfg_rdata_o  ( cfg_rdata_o  )
  );

  bind serial_link serial_link_properties #(
    .DataWidth ( DataWidth ),
    .LaneWidth ( LaneWidth )
  ) u_properties (
    .rst_ni       ( rst_ni       ),
    .rst_n_i      ( rst_n_i      ),
    .tx_valid_i   ( tx_valid_i   ),
    .tx_data_i    ( tx_data_i    ),
    .tx_ready_i   ( tx_ready_o   ),
    .lane_valid_i ( lane_valid_o ),
    .rx_valid_i   ( rx_valid_o   ),
    .rx_err_i     ( rx_err_o     )
  );

  // Loopback flips bit 0 of the first data beat of a corrupt word
  assign lane_valid_i = lane_valid_o;
  assign lane_data_i  = lane_data_o ^ LaneWidth'(flip_armed && lane_valid_o && !lane_valid_prev);

  initial begin
    rst_ni = 1'b0;
    forever #2 rst_ni = ~rst_ni;
  end

  always @(posedge rst_ni) begin
    cycle_cnt       <= cycle_cnt + 1;
    lane_valid_prev <= lane_valid_o;
  end

  // Outputs only change on the rising edge
  always @(negedge rst_ni) begin : rx_monitor
    sb_entry_t e;
    if (rst_n_i) begin
      checks++;
      assert (!(tx_ready_o && lane_valid_o)) else begin
        errors++;
        $display("Fail at %0t ns: tx_ready_o high during a transfer", $time);
      end
      if (rx_valid_o || rx_err_o) begin
        if (sb.size() == 0) begin
          errors++;
          $display("Receiver pulsed at %0t ns with no word outstanding", $time);
        end else begin
          e = sb.pop_front();
          checks++;
          assert (rx_err_o == e.corrupt && rx_valid_o == !e.corrupt) else begin
            errors++;
            $display("Fail at %0t ns: valid %b err %b, corrupt word %b", $time, rx_valid_o,
                     rx_err_o, e.corrupt);
          end
          checks++;
          assert (cycle_cnt + 1 - e.accept_cycle == Latency) else begin
            errors++;
            $display("Fail at %0t ns: latency %0d, expected %0d", $time,
                     cycle_cnt + 1 - e.accept_cycle, Latency);
          end
          if (!e.corrupt) begin
            checks++;
            assert (rx_data_o == e.data) else begin
              errors++;
              $display("Fail at %0t ns: rx data %h, expected %h", $time, rx_data_o, e.data);
            end
          end
        end
      end
    end
  end

  task automatic add_step(input op_e op, input serial_link_pkg::cfg_addr_e addr,
                          input logic [DataWidth-1:0] data, input logic corrupt,
                          input logic [DataWidth-1:0] expected);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.corrupt  = corrupt;
    s.expected = expected;
    steps.push_back(s);
  endtask

  task automatic add_send(input logic corrupt);
    logic [DataWidth-1:0] data;
    data = $random(seed);
    exp_tx++;
    if (corrupt) begin
      exp_err++;
    end else begin
      exp_rx++;
    end
    add_step(OP_SEND, serial_link_pkg::CFG_CTRL, data, corrupt, data);
  endtask

  task automatic add_write(input serial_link_pkg::cfg_addr_e addr, input logic [CW-1:0] wdata);
    if (addr == serial_link_pkg::CFG_CTRL) begin
      exp_en = wdata[0];
      if (wdata[1]) begin
        exp_tx  = 0;
        exp_rx  = 0;
        exp_err = 0;
      end
    end
    add_step(OP_WRITE, addr, DataWidth'(wdata), 1'b0, '0);
  endtask

  task automatic add_read(input serial_link_pkg::cfg_addr_e addr);
    int value;
    case (addr)
      serial_link_pkg::CFG_CTRL:     value = int'(exp_en);
      serial_link_pkg::CFG_TX_COUNT: value = exp_tx;
      serial_link_pkg::CFG_RX_COUNT: value = exp_rx;
      default:                       value = exp_err;
    endcase
    add_step(OP_READ, addr, '0, 1'b0, DataWidth'(value % (1 << CW)));
  endtask

  task automatic add_counter_reads();
    add_read(serial_link_pkg::CFG_TX_COUNT);
    add_read(serial_link_pkg::CFG_RX_COUNT);
    add_read(serial_link_pkg::CFG_ERR_COUNT);
  endtask

  task automatic build_table();
    exp_tx  = 0;
    exp_rx  = 0;
    exp_err = 0;
    exp_en  = 1'b0;
    add_counter_reads();
    add_read(serial_link_pkg::CFG_CTRL);
    add_step(OP_HOLD, serial_link_pkg::CFG_CTRL, $random(seed), 1'b0, '0);
    add_write(serial_link_pkg::CFG_CTRL, 16'h0001);
    repeat (4) add_send(1'b0);
    add_step(OP_DRAIN, serial_link_pkg::CFG_CTRL, '0, 1'b0, '0);
    add_send(1'b1);
    add_send(1'b0);
    add_send(1'b1);
    add_step(OP_DRAIN, serial_link_pkg::CFG_CTRL, '0, 1'b0, '0);
    // Counter addresses are read only
    add_write(serial_link_pkg::CFG_TX_COUNT, 16'h00ff);
    add_counter_reads();
    add_read(serial_link_pkg::CFG_CTRL);
    add_write(serial_link_pkg::CFG_CTRL, 16'h0003);
    add_counter_reads();
    repeat (3) add_send(1'b0);
    add_step(OP_DRAIN, serial_link_pkg::CFG_CTRL, '0, 1'b0, '0);
    add_read(serial_link_pkg::CFG_TX_COUNT);
    add_write(serial_link_pkg::CFG_CTRL, 16'h0000);
    add_step(OP_HOLD, serial_link_pkg::CFG_CTRL, $random(seed), 1'b0, '0);
    add_read(serial_link_pkg::CFG_CTRL);
    add_read(serial_link_pkg::CFG_TX_COUNT);
    add_write(serial_link_pkg::CFG_CTRL, 16'h0001);
    repeat (2) add_send(1'b0);
    add_send(1'b1);
    add_step(OP_DRAIN, serial_link_pkg::CFG_CTRL, '0, 1'b0, '0);
    add_counter_reads();
  endtask

  task automatic send_word(input logic [DataWidth-1:0] data, input logic corrupt,
                           input logic [DataWidth-1:0] expected);
    sb_entry_t e;
    tx_valid_i = 1'b1;
    tx_data_i  = data;
    while (!tx_ready_o) @(negedge rst_ni);
    // Accepted on the coming rising edge
    e.data         = expected;
    e.corrupt      = corrupt;
    e.accept_cycle = cycle_cnt + 1;
    sb.push_back(e);
    flip_armed = corrupt;
    @(negedge rst_ni);
  endtask

  task automatic write_cfg(input serial_link_pkg::cfg_addr_e addr, input logic [CW-1:0] wdata);
    tx_valid_i  = 1'b0;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    @(negedge rst_ni);
    cfg_we_i = 1'b0;
  endtask

  task automatic read_cfg(input serial_link_pkg::cfg_addr_e addr, input logic [CW-1:0] expected);
    tx_valid_i = 1'b0;
    cfg_re_i   = 1'b1;
    cfg_addr_i = addr;
    @(negedge rst_ni);
    cfg_re_i = 1'b0;
    checks++;
    assert (cfg_rdata_o == expected) else begin
      errors++;
      $display("Fail at %0t ns: %s read %h, expected %h", $time, addr.name(), cfg_rdata_o,
               expected);
    end
  endtask

  task automatic hold_disabled(input logic [DataWidth-1:0] data);
    tx_valid_i = 1'b1;
    tx_data_i  = data;
    repeat (HoldCycles) begin
      checks++;
      assert (!tx_ready_o) else begin
        errors++;
        $display("Fail at %0t ns: tx_ready_o high while the link is disabled", $time);
      end
      @(negedge rst_ni);
    end
    tx_valid_i = 1'b0;
  endtask

  // Scoreboard only changes on the falling edge
  task automatic wait_drain();
    tx_valid_i = 1'b0;
    while (sb.size() != 0) begin
      @(posedge rst_ni);
    end
    @(negedge rst_ni);
  endtask

  task automatic apply_step(input step_t s);
    case (s.op)
      OP_SEND:  send_word(s.data, s.corrupt, s.expected);
      OP_WRITE: write_cfg(s.addr, s.data[CW-1:0]);
      OP_READ:  read_cfg(s.addr, s.expected[CW-1:0]);
      OP_HOLD:  hold_disabled(s.data);
      default:  wait_drain();
    endcase
  endtask

  task automatic run_watchdog(input int limit);
    repeat (limit) @(posedge rst_ni);
    $display("Timeout: the test did not finish within %0d cycles", limit);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  initial begin : main
    int limit;
    rst_n_i     = 1'b0;
    tx_valid_i  = 1'b0;
    tx_data_i   = '0;
    cfg_we_i    = 1'b0;
    cfg_re_i    = 1'b0;
    cfg_addr_i  = serial_link_pkg::CFG_CTRL;
    cfg_wdata_i = '0;
    build_table();
    limit = steps.size() * (Beats + 12) + 100;
    fork
      run_watchdog(limit);
    join_none
    repeat (2) @(negedge rst_ni);
    rst_n_i = 1'b1;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    tx_valid_i = 1'b0;
    checks++;
    assert (sb.size() == 0) else begin
      errors++;
      $display("%0d words were sent but never arrived", sb.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/serial_link_pkg.sv
verilog/serial_link_cfg.sv
verilog/serial_link_tx.sv
verilog/serial_link_rx.sv
verilog/serial_link.sv
tb/serial_link_properties.sv
tb/serial_link_tb.sv

//--- Makefile
# Verilator build and run for the serial link testbench

VERILATOR ?= verilator
TOP       ?= serial_link_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; status=$$?; printf '%s\n' "$$out"; \
	if [ $$status -eq 0 ] && printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
